// File: hdl/card_pkg.sv
package card_pkg;

    // keypad codes, one deal key per player
    localparam logic [3:0] key_deal0 = 4'b0011;
    localparam logic [3:0] key_deal1 = 4'b0001;

    // card generator starting point
    localparam logic [4:0] lfsr_seed = 5'b11100;

    // dealt-card queue sizing
    localparam int queue_depth = 4;
    localparam int queue_ptr_w = 2;

    // one color adding up to this rings the bell
    localparam int bell_sum = 5;

    // 0 means no card in both
    typedef logic [1:0] color_t;
    typedef logic [2:0] number_t;
    typedef logic [7:0] count_t;

    // lfsr word split into its two selects
    typedef struct packed {
        logic [1:0] color_sel;
        logic [2:0] number_sel;
    } card_sel_t;

    typedef union packed {
        logic [4:0] raw;
        card_sel_t  sel;
    } card_word_u;

    // select 3 folds back onto color 1
    function automatic color_t decode_color(input logic [1:0] sel);
        case (sel)
            2'd0:    return 2'd1;
            2'd1:    return 2'd2;
            2'd2:    return 2'd3;
            default: return 2'd1;
        endcase
    endfunction

    // 0..4 give 1..5, 5..7 wrap to 1..3
    function automatic number_t decode_number(input logic [2:0] sel);
        if (sel <= 3'd4) begin
            return sel + 3'd1;
        end
        return sel - 3'd4;
    endfunction

    // host register map
    localparam logic [7:0] reg_status = 8'h00;
    localparam logic [7:0] reg_card0  = 8'h04;
    localparam logic [7:0] reg_card1  = 8'h08;
    localparam logic [7:0] reg_counts = 8'h0C;

endpackage

// File: hdl/deal_if.sv
`timescale 1ns/1ps

// one card plus its owner, valid/ready handshake
interface deal_if import card_pkg::*; ();

    logic       valid;
    logic       ready;
    card_word_u card;
    // owning player, 0 or 1
    logic       player;

    // card source side
    modport sender (
        output valid,
        output card,
        output player,
        input  ready
    );

    // card sink side
    modport receiver (
        input  valid,
        input  card,
        input  player,
        output ready
    );

endinterface

// File: hdl/card_dealer.sv
`timescale 1ns/1ps

module card_dealer import card_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic [3:0] keypad,
    deal_if.sender deal
);

    // player whose turn it is
    logic       turn;
    // current card generator state
    logic [4:0] lfsr;
    logic [4:0] lfsr_next;
    // dealt word as seen by the tracker through its selects
    card_word_u dealt;
    logic       key_match;
    logic       xfer;

    // only the key of the player on turn counts
    always_comb begin
        if (turn == 1'b0) begin
            key_match = (keypad == key_deal0);
        end else begin
            key_match = (keypad == key_deal1);
        end
    end

    // card is the lfsr value before the step
    assign dealt.raw = lfsr;

    // offer follows the key level
    assign deal.valid  = key_match;
    assign deal.player = turn;
    assign deal.card   = dealt;

    // queue took the card this cycle
    assign xfer = deal.valid && deal.ready;

    // shift left with feedback from taps 2 and 4
    always_comb begin
        lfsr_next    = {lfsr[3:0], 1'b0};
        lfsr_next[0] = lfsr[2] ^ lfsr[4];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            turn <= 1'b0;
            lfsr <= lfsr_seed;
        end else begin
            // a dropped press leaves turn and lfsr alone
            if (xfer) begin
                turn <= ~turn;
                lfsr <= lfsr_next;
            end
        end
    end

    // maximal-length taps never reach the all-zero lockup
    a_lfsr_nonzero: assert property (
        @(posedge clk) disable iff (!rst)
        lfsr != 5'd0
    );

    // turn only moves after a card left for the queue
    a_turn_on_xfer: assert property (
        @(posedge clk) disable iff (!rst)
        $past(rst) && (turn != $past(turn)) |-> $past(xfer)
    );

endmodule

// File: hdl/card_queue.sv
`timescale 1ns/1ps

module card_queue import card_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    deal_if.receiver push,
    deal_if.sender   pop
);

    // storage, payload only
    card_word_u card_mem   [queue_depth];
    logic       player_mem [queue_depth];

    logic [queue_ptr_w-1:0] wr_ptr;
    logic [queue_ptr_w-1:0] rd_ptr;
    // occupancy, one bit wider than the pointers
    logic [queue_ptr_w:0]   count;

    logic full;
    logic empty;
    logic do_push;
    logic do_pop;

    assign full  = (int'(count) == queue_depth);
    assign empty = (count == '0);

    // dealer blocked once all slots hold cards
    assign push.ready = !full;
    // head slot straight from storage, stable until popped
    assign pop.valid  = !empty;
    assign pop.card   = card_mem[rd_ptr];
    assign pop.player = player_mem[rd_ptr];

    assign do_push = push.valid && push.ready;
    assign do_pop  = pop.valid && pop.ready;

    always_ff @(posedge clk) begin
        if (do_push) begin
            card_mem[wr_ptr]   <= push.card;
            player_mem[wr_ptr] <= push.player;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // full and not draining, nothing may slip in
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst)
        full && !do_pop |=> count == $past(count)
    );

    // empty and not filling, nothing may leave
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst)
        empty && !do_push |=> empty
    );

endmodule

// File: hdl/table_tracker.sv
`timescale 1ns/1ps

module table_tracker import card_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    deal_if.receiver    cards,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [15:0] pwdata,
    output logic [15:0] prdata,
    output logic        bell
);

    // face-up card and deal count per player
    color_t  [1:0] face_color;
    number_t [1:0] face_number;
    logic    [1:0] face_valid;
    count_t  [1:0] deal_count;

    color_t  [1:0] nxt_color;
    number_t [1:0] nxt_number;
    logic    [1:0] nxt_valid;
    count_t  [1:0] nxt_count;
    logic          nxt_bell;

    card_word_u word;
    logic       take;
    logic       clear_wr;

    // per-color total of the face-up cards hits bell_sum
    function automatic logic bell_rule(
        input color_t  [1:0] col,
        input number_t [1:0] num,
        input logic    [1:0] vld
    );
        logic       same;
        logic [3:0] total;
        same  = vld[0] && vld[1] && (col[0] == col[1]);
        total = {1'b0, num[0]} + {1'b0, num[1]};
        if (same) begin
            return total == 4'(bell_sum);
        end
        // different colors, each card stands alone
        return (vld[0] && num[0] == 3'(bell_sum)) || (vld[1] && num[1] == 3'(bell_sum));
    endfunction

    // table frozen while the bell rings
    assign cards.ready = !bell;
    assign take        = cards.valid && cards.ready;
    assign word        = cards.card;

    // end of access cycle, status write with bit 0
    assign clear_wr = psel && penable && pwrite && (paddr == reg_status) && pwdata[0];

    always_comb begin
        nxt_color  = face_color;
        nxt_number = face_number;
        nxt_valid  = face_valid;
        nxt_count  = deal_count;
        // clear first, a card popped in the same cycle lands on a clean table
        if (clear_wr) begin
            nxt_color  = '0;
            nxt_number = '0;
            nxt_valid  = '0;
            nxt_count  = '0;
        end
        if (take) begin
            nxt_color[cards.player]  = decode_color(word.sel.color_sel);
            nxt_number[cards.player] = decode_number(word.sel.number_sel);
            nxt_valid[cards.player]  = 1'b1;
            // wraps past 255
            nxt_count[cards.player]  = nxt_count[cards.player] + 8'd1;
        end
    end

    // bell is only re-evaluated when a card turns over
    always_comb begin
        if (take) begin
            nxt_bell = bell_rule(nxt_color, nxt_number, nxt_valid);
        end else if (clear_wr) begin
            nxt_bell = 1'b0;
        end else begin
            nxt_bell = bell;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            face_color  <= '0;
            face_number <= '0;
            face_valid  <= '0;
            deal_count  <= '0;
            bell        <= 1'b0;
        end else begin
            face_color  <= nxt_color;
            face_number <= nxt_number;
            face_valid  <= nxt_valid;
            deal_count  <= nxt_count;
            bell        <= nxt_bell;
        end
    end

    // read mux, no wait states
    always_comb begin
        case (paddr)
            reg_status: prdata = {13'd0, face_valid[1], face_valid[0], bell};
            reg_card0:  prdata = {11'd0, face_color[0], face_number[0]};
            reg_card1:  prdata = {11'd0, face_color[1], face_number[1]};
            reg_counts: prdata = {deal_count[1], deal_count[0]};
            default:    prdata = 16'd0;
        endcase
    end

    // ringing bell holds the table until the host clears it
    a_no_pop_bell: assert property (
        @(posedge clk) disable iff (!rst)
        bell && !clear_wr |=> bell && $stable(deal_count) && $stable(face_number)
    );

endmodule

// File: hdl/card_table_top.sv
`timescale 1ns/1ps

module card_table_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  keypad,
    // host register port
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [15:0] pwdata,
    output logic [15:0] prdata,
    // lamp driver
    output logic        bell
);

    // dealer to queue
    deal_if deal_in ();
    // queue to tracker
    deal_if deal_out ();

    // keypad presses become cards
    card_dealer u_dealer (
        .clk    (clk),
        .rst    (rst),
        .keypad (keypad),
        .deal   (deal_in)
    );

    // up to four cards wait here while the bell rings
    card_queue u_queue (
        .clk  (clk),
        .rst  (rst),
        .push (deal_in),
        .pop  (deal_out)
    );

    // face-up state, bell and host registers
    table_tracker u_tracker (
        .clk     (clk),
        .rst     (rst),
        .cards   (deal_out),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .bell    (bell)
    );

endmodule

// File: testbench/tb_card_table.sv
`timescale 1ns/1ps

module tb_card_table import card_pkg::*; ();

    localparam int clk_period   = 20;
    localparam int num_directed = 8;
    localparam int num_random   = 300;
    // a single step can pull in a full back-pressure round, 8 steps at most
    localparam int max_steps       = (num_directed + num_random) * 8;
    localparam int watchdog_cycles = max_steps * 200 + 1000;

    logic        clk;
    logic        rst;
    logic [3:0]  keypad;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic        bell;

    // table model, queue entries are {player, card}
    logic       m_turn;
    logic [4:0] m_lfsr;
    logic [5:0] m_queue [$];
    logic [1:0] m_color [2];
    logic [2:0] m_number [2];
    logic [1:0] m_valid;
    logic [7:0] m_count [2];
    logic       m_bell;

    // register map walked in this order
    logic [7:0]  reg_addr [4] = '{reg_status, reg_card0, reg_card1, reg_counts};
    string       reg_names [4] = '{"status", "card0", "card1", "counts"};
    logic [15:0] rd_regs [4];
    logic [15:0] exp_regs [4];
    logic        rd_bell;
    logic        exp_bell;
    string       test_name;
    integer      seed;
    integer      rnd;
    int          errors = 0;
    int          checks = 0;
    int          deals = 0;
    event        check_ev;

    card_table_top uut (
        .clk     (clk),
        .rst     (rst),
        .keypad  (keypad),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .bell    (bell)
    );

    always #(clk_period / 2) clk = ~clk;

    // shift left, new bit from taps 2 and 4
    function automatic logic [4:0] lfsr_step(input logic [4:0] x);
        return {x[3:0], x[2] ^ x[4]};
    endfunction

    // top two bits pick the color, 3 folds back to color 1
    function automatic logic [1:0] card_color(input logic [4:0] card);
        if (card[4:3] == 2'd3) begin
            return 2'd1;
        end
        return card[4:3] + 2'd1;
    endfunction

    // low three bits, 5..7 wrap around to 1..3
    function automatic logic [2:0] card_number(input logic [4:0] card);
        int v;
        v = int'(card[2:0]) % 5 + 1;
        return 3'(v);
    endfunction

    // any color whose face-up numbers total five
    function automatic logic bell_rings(input logic [1:0] c0, input logic [2:0] n0,
                                        input logic v0, input logic [1:0] c1,
                                        input logic [2:0] n1, input logic v1);
        int total;
        for (int c = 1; c <= 3; c++) begin
            total = 0;
            if (v0 && c0 == c) begin
                total += n0;
            end
            if (v1 && c1 == c) begin
                total += n1;
            end
            if (total == bell_sum) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic model_clear_table();
        for (int p = 0; p < 2; p++) begin
            m_color[p]  = 2'd0;
            m_number[p] = 3'd0;
            m_count[p]  = 8'd0;
        end
        m_valid = 2'b00;
        m_bell  = 1'b0;
    endtask

    // head card turns face up for its player
    task automatic model_pop();
        logic [5:0] entry;
        entry = m_queue.pop_front();
        m_color[entry[5]]  = card_color(entry[4:0]);
        m_number[entry[5]] = card_number(entry[4:0]);
        m_valid[entry[5]]  = 1'b1;
        m_count[entry[5]]  = m_count[entry[5]] + 8'd1;
        m_bell = bell_rings(m_color[0], m_number[0], m_valid[0],
                            m_color[1], m_number[1], m_valid[1]);
    endtask

    // draining stops as soon as a card rings the bell
    task automatic model_drain();
        while (m_queue.size() > 0 && !m_bell) begin
            model_pop();
        end
    endtask

    task automatic model_press(input logic [3:0] key);
        logic [3:0] want;
        want = m_turn ? key_deal1 : key_deal0;
        // full queue drops the press, turn and lfsr stay put
        if (key == want && m_queue.size() < queue_depth) begin
            m_queue.push_back({m_turn, m_lfsr});
            m_turn = ~m_turn;
            m_lfsr = lfsr_step(m_lfsr);
            deals++;
        end
        model_drain();
    endtask

    // setup cycle then access cycle, read data taken mid access
    task automatic apb_read(input logic [7:0] addr, output logic [15:0] data);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #(clk_period / 4);
        data = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [15:0] data);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic sample_and_compare(input string name);
        logic [15:0] data;
        for (int i = 0; i < 4; i++) begin
            apb_read(reg_addr[i], data);
            rd_regs[i] = data;
        end
        rd_bell     = bell;
        exp_regs[0] = {13'd0, m_valid[1], m_valid[0], m_bell};
        exp_regs[1] = {11'd0, m_color[0], m_number[0]};
        exp_regs[2] = {11'd0, m_color[1], m_number[1]};
        exp_regs[3] = {m_count[1], m_count[0]};
        exp_bell    = m_bell;
        test_name   = name;
        -> check_ev;
    endtask

    // one cycle with the key, one idle cycle
    task automatic press_step(input logic [3:0] key, input string name);
        keypad = key;
        @(negedge clk);
        keypad = 4'd0;
        @(negedge clk);
        model_press(key);
        sample_and_compare(name);
    endtask

    task automatic clear_step(input string name);
        apb_write(reg_status, 16'h0001);
        // queued cards drain one per cycle after the clear
        repeat (queue_depth + 1) @(negedge clk);
        model_clear_table();
        model_drain();
        sample_and_compare(name);
    endtask

    // fill the queue behind the bell, overflow it, then clear
    task automatic backpressure_round();
        repeat (queue_depth + 2) begin
            press_step(m_turn ? key_deal1 : key_deal0, "backpressure");
        end
        clear_step("clear after bell");
    endtask

    always @(check_ev) begin
        for (int i = 0; i < 4; i++) begin
            checks++;
            if (rd_regs[i] !== exp_regs[i]) begin
                errors++;
                $display("error %s: %s expected %h, actual %h",
                         test_name, reg_names[i], exp_regs[i], rd_regs[i]);
            end
        end
        checks++;
        if (rd_bell !== exp_bell) begin
            errors++;
            $display("error %s: bell pin expected %b, actual %b", test_name, exp_bell, rd_bell);
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout: run still going after %0d cycles", watchdog_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        clk     = 1'b0;
        rst     = 1'b0;
        keypad  = 4'd0;
        paddr   = 8'd0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = 16'd0;
        seed    = 27742;
        m_turn  = 1'b0;
        m_lfsr  = lfsr_seed;
        m_queue.delete();
        model_clear_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        sample_and_compare("reset");
        // wrong player first, junk codes, then alternating deals
        for (int i = 0; i < num_directed; i++) begin
            case (i)
                0, 3:    press_step(key_deal1, "turn");
                1, 2, 6: press_step(key_deal0, "turn");
                4:       press_step(4'hF, "turn");
                5:       press_step(key_deal1, "turn");
                default: press_step(4'h2, "turn");
            endcase
            if (m_bell) begin
                backpressure_round();
            end
        end
        for (int i = 0; i < num_random; i++) begin
            rnd = $random(seed);
            press_step(rnd[3:0], "random");
            if (m_bell) begin
                backpressure_round();
            end
        end
        // clear with a quiet table, then dealing picks up where it was
        clear_step("final clear");
        press_step(m_turn ? key_deal1 : key_deal0, "resume");
        repeat (2) @(negedge clk);
        $display("checks %0d, deals %0d, errors %0d", checks, deals, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
hdl/card_pkg.sv
hdl/deal_if.sv
hdl/card_dealer.sv
hdl/card_queue.sv
hdl/table_tracker.sv
hdl/card_table_top.sv
testbench/tb_card_table.sv

// File: Makefile
# verilator flow for the card table

VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= tb_card_table
RTL_TOP    ?= card_table_top
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= TESTBENCH PASSED
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
SIM_BIN    := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

# rtl top only
lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# exit status follows the pass line in the output
sim: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -q "$(PASS_MSG)"; then \
		echo "sim: pass line found"; \
	else \
		echo "sim: pass line missing"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
